//--- source/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Byte address width
`define ADDR_WIDTH 16

// Processor and memory word width
`define WORD_WIDTH 16

// Direct mapped, one line per set
`define CACHE_SETS 8

// 16 byte blocks of 16 bit words
`define WORDS_PER_BLOCK 8

`endif

//--- source/cache_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

  localparam int WORD_BYTES  = `WORD_WIDTH / 8;
  localparam int OFFSET_BITS = $clog2(`WORDS_PER_BLOCK * WORD_BYTES);
  localparam int INDEX_BITS  = $clog2(`CACHE_SETS);
  localparam int TAG_BITS    = `ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`WORD_WIDTH-1:0] word_t;
  typedef logic [TAG_BITS-1:0]    tag_t;
  typedef logic [INDEX_BITS-1:0]  index_t;
  typedef logic [OFFSET_BITS-1:0] offset_t; // Byte offset, bit 0 always clear

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,   // Issuing block addresses
    DRAIN,     // Waiting for the remaining beats
    WRITE_TAG
  } fill_state_t;

  // Address fields: | tag | index | offset |
  function automatic tag_t get_tag(addr_t a);
    return a[`ADDR_WIDTH-1 -: TAG_BITS];
  endfunction

  function automatic index_t get_index(addr_t a);
    return a[OFFSET_BITS +: INDEX_BITS];
  endfunction

  function automatic offset_t get_offset(addr_t a);
    return a[OFFSET_BITS-1:0];
  endfunction

endpackage

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package mem_pkg;

  // Wide enough to hold a full block count, 0 to 8
  typedef logic [$clog2(`WORDS_PER_BLOCK + 1)-1:0] beat_count_t;

  typedef logic [`WORD_WIDTH-1:0] mem_word_t; // Read data bus
  typedef logic [`ADDR_WIDTH-1:0] mem_addr_t; // Byte address bus

endpackage

`default_nettype wire

//--- source/fill_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fill_if import cache_pkg::*; ();

  logic  write_data;  // One pulse per memory beat
  addr_t wr_address;  // Where the beat lands in the block
  word_t wr_data;
  logic  write_tag;   // Pulse once the block is complete
  addr_t tag_address; // Block base of the fill
  logic  busy;        // Fill in progress

  modport ctrl (
    output write_data,
    output wr_address,
    output wr_data,
    output write_tag,
    output tag_address,
    output busy
  );

  modport tag (
    input write_tag,
    input tag_address,
    input busy
  );

  modport data (
    input write_data,
    input wr_address,
    input wr_data
  );

endinterface

`default_nettype wire

//--- source/cache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_lookup
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req_valid,
  input  addr_t req_address,
  fill_if.tag   fill,
  output logic  hit,
  output logic  miss
);

  tag_t                   tags_q [`CACHE_SETS];
  logic [`CACHE_SETS-1:0] valid_q;

  tag_t   req_tag;
  index_t req_index;
  tag_t   fill_tag;
  index_t fill_index;
  logic   tag_match;

  assign req_tag    = get_tag(req_address);
  assign req_index  = get_index(req_address);
  assign fill_tag   = get_tag(fill.tag_address);
  assign fill_index = get_index(fill.tag_address);

  // Tag storage, one entry per set
  always_ff @(posedge clk) begin
    if (fill.write_tag) begin
      tags_q[fill_index] <= fill_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (fill.write_tag) begin
      valid_q[fill_index] <= 1'b1; // Line complete
    end
  end

  assign tag_match = valid_q[req_index] && (tags_q[req_index] == req_tag);

  // Hit is combinational, answered in the request cycle
  assign hit = req_valid && tag_match;

  // Only one fill at a time
  assign miss = req_valid && !tag_match && !fill.busy;

  // A tag update belongs to a running fill
  a_tag_in_fill : assert property (
    @(posedge clk) disable iff (!rst_n)
    fill.write_tag |-> fill.busy
  );

  // The controller picks up every miss on the next edge
  a_miss_starts_fill : assert property (
    @(posedge clk) disable iff (!rst_n)
    miss |=> fill.busy
  );

endmodule

`default_nettype wire

//--- source/cache_fill_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_fill_fsm
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      miss,
  input  addr_t     req_address,
  output logic      mem_read,
  output mem_addr_t mem_address,
  input  mem_word_t mem_data,
  input  logic      mem_data_valid,
  fill_if.ctrl      fill
);

  localparam beat_count_t BLOCK_BEATS = beat_count_t'(`WORDS_PER_BLOCK);
  localparam beat_count_t LAST_BEAT   = beat_count_t'(`WORDS_PER_BLOCK - 1);
  localparam addr_t       WORD_STEP   = addr_t'(WORD_BYTES);

  fill_state_t state_q;
  fill_state_t state_d;

  beat_count_t issue_cnt_q; // Addresses sent to memory
  beat_count_t rx_cnt_q;    // Data beats received

  addr_t     base_q;     // Block base, kept for the tag write
  mem_addr_t mem_addr_q; // Next address to issue
  addr_t     wr_addr_q;  // Next word to fill in the data array

  addr_t base_address;
  logic  filling;
  logic  beat;

  assign base_address = {req_address[`ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

  // Beats can arrive during REQUEST as well as DRAIN
  assign filling = (state_q == REQUEST) || (state_q == DRAIN);
  assign beat    = mem_data_valid && filling;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (miss) begin
          state_d = REQUEST;
        end
      end
      REQUEST: begin
        if (issue_cnt_q == LAST_BEAT) begin
          state_d = DRAIN; // Eighth address goes out this cycle
        end
      end
      DRAIN: begin
        if (beat && (rx_cnt_q == LAST_BEAT)) begin
          state_d = WRITE_TAG;
        end
      end
      WRITE_TAG: state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      issue_cnt_q <= '0;
      rx_cnt_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE) begin
        issue_cnt_q <= '0;
        rx_cnt_q    <= '0;
      end else begin
        if (mem_read) begin
          issue_cnt_q <= issue_cnt_q + 1'b1;
        end
        if (beat) begin
          rx_cnt_q <= rx_cnt_q + 1'b1;
        end
      end
    end
  end

  // Working addresses, both start at the block base
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && miss) begin
      base_q     <= base_address;
      mem_addr_q <= base_address;
      wr_addr_q  <= base_address;
    end else begin
      if (mem_read) begin
        mem_addr_q <= mem_addr_q + WORD_STEP; // Every issue cycle
      end
      if (beat) begin
        wr_addr_q <= wr_addr_q + WORD_STEP;   // Only on valid data
      end
    end
  end

  assign mem_read    = (state_q == REQUEST);
  assign mem_address = mem_addr_q;

  assign fill.busy        = (state_q != IDLE);
  assign fill.write_data  = beat;
  assign fill.wr_address  = wr_addr_q;
  assign fill.wr_data     = mem_data;
  assign fill.write_tag   = (state_q == WRITE_TAG);
  assign fill.tag_address = base_q;

  // The burst stops after a full block of addresses
  a_issue_limit : assert property (
    @(posedge clk) disable iff (!rst_n)
    (issue_cnt_q == BLOCK_BEATS) |-> !mem_read
  );

  // Memory only answers addresses of the current fill
  a_data_in_fill : assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_data_valid |-> filling
  );

endmodule

`default_nettype wire

//--- source/cache_data_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_data_array
  import cache_pkg::*;
(
  input  logic  clk,
  fill_if.data  fill,
  input  addr_t req_address,
  output word_t rsp_data
);

  localparam int WORD_SEL_BITS = $clog2(`WORDS_PER_BLOCK);

  // One block of words per set
  word_t data_q [`CACHE_SETS][`WORDS_PER_BLOCK];

  index_t                   wr_index;
  offset_t                  wr_offset;
  logic [WORD_SEL_BITS-1:0] wr_word;

  index_t                   rd_index;
  offset_t                  rd_offset;
  logic [WORD_SEL_BITS-1:0] rd_word;

  assign wr_index  = get_index(fill.wr_address);
  assign wr_offset = get_offset(fill.wr_address);
  assign wr_word   = wr_offset[OFFSET_BITS-1 -: WORD_SEL_BITS]; // Drop the byte bit

  assign rd_index  = get_index(req_address);
  assign rd_offset = get_offset(req_address);
  assign rd_word   = rd_offset[OFFSET_BITS-1 -: WORD_SEL_BITS];

  always_ff @(posedge clk) begin
    if (fill.write_data) begin
      data_q[wr_index][wr_word] <= fill.wr_data;
    end
  end

  // Asynchronous read for the zero cycle hit path
  assign rsp_data = data_q[rd_index][rd_word];

endmodule

`default_nettype wire

//--- source/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_top
  import cache_pkg::*;
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Processor side
  input  logic      req_valid,
  input  addr_t     req_address,
  output logic      rsp_valid,
  output word_t     rsp_data,
  output logic      busy,

  // Memory side
  output logic      mem_read,
  output mem_addr_t mem_address,
  input  mem_word_t mem_data,
  input  logic      mem_data_valid
);

  logic miss;

  fill_if fill_bus ();

  // Decode, tag check
  cache_lookup u_lookup (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req_address (req_address),
    .fill        (fill_bus.tag),
    .hit         (rsp_valid), // A hit is the response
    .miss        (miss)
  );

  // Execute, block fill
  cache_fill_fsm u_fill_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .miss           (miss),
    .req_address    (req_address),
    .mem_read       (mem_read),
    .mem_address    (mem_address),
    .mem_data       (mem_data),
    .mem_data_valid (mem_data_valid),
    .fill           (fill_bus.ctrl)
  );

  // Result, word storage and read
  cache_data_array u_data_array (
    .clk         (clk),
    .fill        (fill_bus.data),
    .req_address (req_address),
    .rsp_data    (rsp_data)
  );

  assign busy = fill_bus.busy;

endmodule

`default_nettype wire

//--- sim/cache_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_top_tb
  import cache_pkg::*;
();

  // Address split of a 16 byte block, direct mapped
  localparam int OFF_W   = $clog2(`WORDS_PER_BLOCK * (`WORD_WIDTH / 8));
  localparam int IDX_W   = $clog2(`CACHE_SETS);
  localparam int TAG_LSB = OFF_W + IDX_W;

  // 1 cold, 8 hit, 3 conflict, 32 irregular, 200 random
  localparam int NUM_REQUESTS   = 244;
  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 40 + RESET_CYCLES;

  logic  clk;
  logic  rst_n;
  logic  req_valid;
  addr_t req_address;
  logic  rsp_valid;
  word_t rsp_data;
  logic  busy;
  logic  mem_read;
  addr_t mem_address;
  word_t mem_data;
  logic  mem_data_valid;

  int    cycle_count;
  int    gap_pct;         // Chance of an idle memory cycle, percent
  addr_t pend_addr [$];   // Issued addresses not yet answered
  int    pend_due [$];
  addr_t burst_addr [$];  // mem_read addresses of the current request
  int    burst_cycle [$];

  logic [`ADDR_WIDTH-1:0] shadow_tag [`CACHE_SETS];
  logic                   shadow_valid [`CACHE_SETS];

  cache_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_address    (req_address),
    .rsp_valid      (rsp_valid),
    .rsp_data       (rsp_data),
    .busy           (busy),
    .mem_read       (mem_read),
    .mem_address    (mem_address),
    .mem_data       (mem_data),
    .mem_data_valid (mem_data_valid)
  );

  always #10 clk = ~clk;

  // Contents of backing memory, scrambled from every address bit
  function automatic word_t mem_word(input addr_t a);
    word_t mix;
    mix = a ^ 16'hB5E3;
    mix = {mix[6:0], mix[15:7]} + (a * 16'd37);
    return mix ^ {a[3:0], a[15:4]};
  endfunction

  function automatic logic predict_hit(input addr_t a);
    int idx;
    idx = int'(a[OFF_W +: IDX_W]);
    return shadow_valid[idx] && (shadow_tag[idx] == (a >> TAG_LSB));
  endfunction

  // Four tags over all sets, even offsets only
  function automatic addr_t random_address();
    int unsigned tag_sel;
    int unsigned set_sel;
    int unsigned word_sel;
    tag_sel  = $urandom % 4;
    set_sel  = $urandom % `CACHE_SETS;
    word_sel = $urandom % `WORDS_PER_BLOCK;
    return addr_t'((tag_sel << TAG_LSB) | (set_sel << OFF_W) | (word_sel << 1));
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED: %s is %h, expected %h", name, actual, expected);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // One processor read, held until rsp_valid
  task automatic read_and_check(input addr_t addr, output logic was_hit);
    logic  exp_hit;
    int    req_cycle;
    int    idx;
    addr_t base;
    exp_hit = predict_hit(addr);
    base    = addr_t'((addr >> OFF_W) << OFF_W);
    @(negedge clk);
    burst_addr.delete();
    burst_cycle.delete();
    req_valid   = 1'b1;
    req_address = addr;
    req_cycle   = cycle_count;
    #1;
    check_value("rsp_valid", rsp_valid, exp_hit);
    was_hit = rsp_valid; // As seen in the request cycle
    if (exp_hit) begin
      check_value("mem_read", mem_read, 1'b0);
    end else begin
      check_value("busy", busy, 1'b0);
      while (rsp_valid !== 1'b1) begin
        @(negedge clk);
        #1;
        if (rsp_valid !== 1'b1) begin
          check_value("busy", busy, 1'b1); // High for the whole fill
        end
      end
      check_value("burst_length", burst_addr.size(), `WORDS_PER_BLOCK);
      for (int i = 0; i < `WORDS_PER_BLOCK; i++) begin
        check_value("mem_address", burst_addr[i], base + addr_t'(2 * i));
        check_value("mem_read_cycle", burst_cycle[i], req_cycle + 1 + i);
      end
      check_value("busy", busy, 1'b0);
      check_value("pending_beats", pend_addr.size(), 0);
      idx = int'(addr[OFF_W +: IDX_W]);
      shadow_tag[idx]   = addr >> TAG_LSB;
      shadow_valid[idx] = 1'b1;
    end
    check_value("rsp_data", rsp_data, mem_word(addr));
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  // Pipelined memory, answers in order after 1 to 4 cycles
  always @(negedge clk) begin
    if (!rst_n) begin
      pend_addr.delete();
      pend_due.delete();
      mem_data_valid = 1'b0;
    end else begin
      if (mem_read) begin
        pend_addr.push_back(mem_address);
        pend_due.push_back(cycle_count + 1 + int'($urandom % 4));
        burst_addr.push_back(mem_address);
        burst_cycle.push_back(cycle_count);
      end
      mem_data_valid = 1'b0;
      if ((pend_addr.size() > 0) && (pend_due[0] <= cycle_count) &&
          (($urandom % 100) >= gap_pct)) begin
        mem_data_valid = 1'b1;
        mem_data       = mem_word(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
    end
  end

  initial begin
    addr_t a_addr;
    addr_t b_addr;
    addr_t base;
    logic  hit;
    int    hits;
    void'($urandom(80));
    clk            = 1'b0;
    rst_n          = 1'b0;
    req_valid      = 1'b0;
    req_address    = '0;
    mem_data       = '0;
    mem_data_valid = 1'b0;
    cycle_count    = 0;
    gap_pct        = 20;
    hits           = 0;
    for (int s = 0; s < `CACHE_SETS; s++) begin
      shadow_tag[s]   = '0;
      shadow_valid[s] = 1'b0;
    end

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    #1;
    check_value("mem_read", mem_read, 1'b0);
    check_value("busy", busy, 1'b0);
    check_value("rsp_valid", rsp_valid, 1'b0);

    // Cold miss, then every word of the filled block
    a_addr = 16'h1234;
    read_and_check(a_addr, hit);
    check_value("cold_hit", hit, 1'b0);
    base = 16'h1230;
    for (int w = 0; w < `WORDS_PER_BLOCK; w++) begin
      read_and_check(base + addr_t'(2 * w), hit);
      check_value("fill_hit", hit, 1'b1);
    end

    // Same set, other tag
    b_addr = a_addr + addr_t'(1 << TAG_LSB);
    read_and_check(b_addr, hit);
    check_value("conflict_hit", hit, 1'b0);
    read_and_check(a_addr, hit);
    check_value("refill_hit", hit, 1'b0);
    read_and_check(b_addr, hit);
    check_value("conflict_hit", hit, 1'b0);

    gap_pct = 60;  // Long gaps between beats
    for (int b = 0; b < 4; b++) begin
      base = addr_t'(16'h4C00 + b * 16'h2350) & 16'hFFF0;
      for (int w = 0; w < `WORDS_PER_BLOCK; w++) begin
        read_and_check(base + addr_t'(2 * ((2 * b + 1 + w) % `WORDS_PER_BLOCK)), hit);
      end
    end

    gap_pct = 25;
    for (int r = 0; r < 200; r++) begin
      read_and_check(random_address(), hit);
      if (hit) begin
        hits++;
      end
    end
    $display("Random mix: %0d hits, %0d misses", hits, 200 - hits);

    @(negedge clk);
    req_valid = 1'b0;
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- cache_top.f
+incdir+source
source/cache_pkg.sv
source/mem_pkg.sv
source/fill_if.sv
source/cache_lookup.sv
source/cache_fill_fsm.sv
source/cache_data_array.sv
source/cache_top.sv
sim/cache_top_tb.sv

//--- Bender.yml
package:
  name: cache_top

sources:
  # Design sources, packages first
  - include_dirs:
      - source
    files:
      - source/cache_pkg.sv
      - source/mem_pkg.sv
      - source/fill_if.sv
      - source/cache_lookup.sv
      - source/cache_fill_fsm.sv
      - source/cache_data_array.sv
      - source/cache_top.sv

  # Testbench
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/cache_top_tb.sv
